// File: fpuIsaPkg.sv
//////////////////////////////
// FP ISA definitions: opcode, funct7 encodings and
// single-precision word layouts
//////////////////////////////

package fpuIsaPkg;

  // Major opcode of OP-FP
  localparam logic [6:0] FpOpcode = 7'b1010011;

  // Funct7 values, fmt field (bits 1:0) is 00 for single
  localparam logic [6:0] Funct7Sgnj     = 7'b0010000;  // fsgnj/fsgnjn/fsgnjx
  localparam logic [6:0] Funct7MinMax   = 7'b0010100;  // fmin/fmax
  localparam logic [6:0] Funct7Cmp      = 7'b1010000;  // feq/flt/fle
  localparam logic [6:0] Funct7MvXClass = 7'b1110000;  // fmv.x.w (f3=000), fclass (f3=001)
  localparam logic [6:0] Funct7MvWX     = 7'b1111000;  // fmv.w.x

  // R-type instruction, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instrR_t;

  // IEEE 754 binary32 fields
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;   // Biased exponent
    logic [22:0] frac;  // Fraction, bit 22 is the quiet bit on NaNs
  } fpFields_t;

  // Same word seen raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    fpFields_t   f;
  } fpWord_u;

  localparam logic [31:0] CanonicalNaN = 32'h7FC00000;  // Positive quiet NaN

endpackage

// File: fpuPipePkg.sv
//////////////////////////////
// FPU pipeline types: stage control, class flags, forwarding select
//////////////////////////////

package fpuPipePkg;

  // Execute result select
  typedef enum logic [2:0] {
    Sgnj,    // Sign injection
    MinMax,  // fmin/fmax
    Cmp,     // feq/flt/fle
    Class,   // fclass
    MvXW,    // FP to integer move
    MvWX     // Integer to FP move
  } resSel_t;

  // Control word carried D -> E -> M -> W, 16 bits
  typedef struct packed {
    logic       valid;      // Slot holds a real instruction
    resSel_t    resSel;
    logic [2:0] funct3;     // Op variant within funct7 group
    logic       fRegWrite;  // Writes FP register file
    logic       intWrite;   // Produces an integer result
    logic       usesX;      // Reads rs1 from FP regs
    logic       usesY;      // Reads rs2 from FP regs
    logic [4:0] rd;
  } fpCtrl_t;

  // fclass layout, qNaN is bit 9 and negInf bit 0
  typedef struct packed {
    logic qNaN;
    logic sNaN;
    logic posInf;
    logic posNorm;
    logic posSub;
    logic posZero;
    logic negZero;
    logic negSub;
    logic negNorm;
    logic negInf;
  } fpClass_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    FwdNone = 2'b00,  // Register file value
    FwdW    = 2'b01,  // Writeback result
    FwdM    = 2'b10   // Memory stage result
  } fwdSel_t;

endpackage

// File: fpuDecoder.sv
//////////////////////////////
// FP instruction decoder with illegal-instruction detection
//////////////////////////////
`timescale 1ns/1ns

module fpuDecoder (
  input  fpuIsaPkg::instrR_t  Instr,
  input  logic                InstrValid,
  output fpuPipePkg::fpCtrl_t Ctrl,
  output logic                IllegalInstr
);
  import fpuIsaPkg::*;
  import fpuPipePkg::*;

  logic legal;  // Word matches a supported op

  always_comb begin
    Ctrl        = '0;
    Ctrl.funct3 = Instr.funct3;
    Ctrl.rd     = Instr.rd;
    legal       = 1'b0;
    if (Instr.opcode == FpOpcode) begin
      case (Instr.funct7)
        Funct7Sgnj: if (Instr.funct3 inside {3'b000, 3'b001, 3'b010}) begin
          legal          = 1'b1;
          Ctrl.resSel    = Sgnj;
          Ctrl.fRegWrite = 1'b1;
          Ctrl.usesX     = 1'b1;
          Ctrl.usesY     = 1'b1;
        end
        Funct7MinMax: if (Instr.funct3 inside {3'b000, 3'b001}) begin
          legal          = 1'b1;
          Ctrl.resSel    = MinMax;
          Ctrl.fRegWrite = 1'b1;
          Ctrl.usesX     = 1'b1;
          Ctrl.usesY     = 1'b1;
        end
        Funct7Cmp: if (Instr.funct3 inside {3'b000, 3'b001, 3'b010}) begin
          legal         = 1'b1;
          Ctrl.resSel   = Cmp;  // fle=000, flt=001, feq=010
          Ctrl.intWrite = 1'b1;
          Ctrl.usesX    = 1'b1;
          Ctrl.usesY    = 1'b1;
        end
        Funct7MvXClass: if (Instr.rs2 == 5'd0 && Instr.funct3[2:1] == 2'b00) begin
          legal         = 1'b1;
          Ctrl.resSel   = Instr.funct3[0] ? Class : MvXW;
          Ctrl.intWrite = 1'b1;
          Ctrl.usesX    = 1'b1;
        end
        Funct7MvWX: if (Instr.rs2 == 5'd0 && Instr.funct3 == 3'b000) begin
          legal          = 1'b1;
          Ctrl.resSel    = MvWX;  // Operand comes from IntSrc
          Ctrl.fRegWrite = 1'b1;
        end
        default: legal = 1'b0;  // Other funct7 or fmt
      endcase
    end
    Ctrl.valid   = InstrValid & legal;
    IllegalInstr = InstrValid & ~legal;
    // A live op writes exactly one destination
    if (!$isunknown({InstrValid, Instr}))
      assert (!Ctrl.valid || (Ctrl.fRegWrite ^ Ctrl.intWrite))
        else $error("decoded op has no single destination");
  end

endmodule

// File: fpuRegFile.sv
//////////////////////////////
// 32x32 FP register file, write-through to reads
//////////////////////////////
`timescale 1ns/1ns

module fpuRegFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        We,
  input  logic [4:0]  Ra1, Ra2, Wa,
  input  logic [31:0] Wd,
  output logic [31:0] Rd1, Rd2
);

  logic [31:0] mem [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) mem[i] <= '0;  // f0..f31 start at +0
    end else if (We) begin
      mem[Wa] <= Wd;
    end
  end

  // Same-cycle write shows up on the read ports
  assign Rd1 = (We && Wa == Ra1) ? Wd : mem[Ra1];
  assign Rd2 = (We && Wa == Ra2) ? Wd : mem[Ra2];

  assert property (@(posedge clk) disable iff (rst) We |-> !$isunknown(Wd))
    else $error("unknown data written to FP register file");

endmodule

// File: fpuForward.sv
//////////////////////////////
// Operand forwarding select, memory stage ahead of writeback
//////////////////////////////
`timescale 1ns/1ns

module fpuForward (
  input  logic [4:0]          Adr1E, Adr2E,
  input  fpuPipePkg::fpCtrl_t CtrlE, CtrlM, CtrlW,
  output fpuPipePkg::fwdSel_t FwdX, FwdY
);
  import fpuPipePkg::*;

  // One source: youngest producer wins
  function automatic fwdSel_t pickSrc(logic used, logic [4:0] adr, fpCtrl_t m, fpCtrl_t w);
    if (used && m.valid && m.fRegWrite && m.rd == adr)
      return FwdM;
    if (used && w.valid && w.fRegWrite && w.rd == adr)
      return FwdW;
    return FwdNone;
  endfunction

  assign FwdX = pickSrc(CtrlE.usesX, Adr1E, CtrlM, CtrlW);  // rs1
  assign FwdY = pickSrc(CtrlE.usesY, Adr2E, CtrlM, CtrlW);  // rs2

endmodule

// File: fpuUnpack.sv
//////////////////////////////
// Splits a binary32 word and classifies it
//////////////////////////////
`timescale 1ns/1ns

module fpuUnpack (
  input  fpuIsaPkg::fpWord_u  X,
  output fpuPipePkg::fpClass_t Cls
);

  logic expZero, expMax, fracZero;
  logic isZero, isSub, isNorm, isInf, isNaN;

  assign expZero  = (X.f.exp == 8'h00);
  assign expMax   = &X.f.exp;
  assign fracZero = (X.f.frac == 23'd0);

  assign isZero = expZero & fracZero;
  assign isSub  = expZero & ~fracZero;   // Denormal, no hidden one
  assign isNorm = ~expZero & ~expMax;
  assign isInf  = expMax & fracZero;
  assign isNaN  = expMax & ~fracZero;

  assign Cls.negInf  = X.f.sign & isInf;
  assign Cls.negNorm = X.f.sign & isNorm;
  assign Cls.negSub  = X.f.sign & isSub;
  assign Cls.negZero = X.f.sign & isZero;
  assign Cls.posZero = ~X.f.sign & isZero;
  assign Cls.posSub  = ~X.f.sign & isSub;
  assign Cls.posNorm = ~X.f.sign & isNorm;
  assign Cls.posInf  = ~X.f.sign & isInf;
  assign Cls.sNaN    = isNaN & ~X.f.frac[22];  // Quiet bit clear
  assign Cls.qNaN    = isNaN & X.f.frac[22];   // NaN sign is ignored

  always_comb begin
    if (!$isunknown(X)) assert ($onehot(Cls)) else $error("class flags not one-hot");
  end

endmodule

// File: fpuCompare.sv
//////////////////////////////
// fmin/fmax and feq/flt/fle with NaN and signed-zero handling
//////////////////////////////
`timescale 1ns/1ns

module fpuCompare (
  input  fpuIsaPkg::fpWord_u   X, Y,
  input  fpuPipePkg::fpClass_t XCls, YCls,
  input  logic [2:0]           Funct3,
  input  logic                 IsMinMax,
  output logic [31:0]          CmpFp,
  output logic                 CmpInt,
  output logic                 Invalid
);
  import fpuIsaPkg::*;

  logic xNaN, yNaN, anyNaN, anySNaN;
  logic bothZero;      // +0 vs -0 in any mix
  logic magLt, magGt;  // Magnitude order
  logic ltTot;         // X below Y, -0 below +0
  logic lt, eq;        // IEEE order, no NaNs

  assign xNaN     = XCls.sNaN | XCls.qNaN;
  assign yNaN     = YCls.sNaN | YCls.qNaN;
  assign anyNaN   = xNaN | yNaN;
  assign anySNaN  = XCls.sNaN | YCls.sNaN;
  assign bothZero = (XCls.negZero | XCls.posZero) & (YCls.negZero | YCls.posZero);

  // Exp and fraction together sort like an unsigned number
  assign magLt = X.raw[30:0] < Y.raw[30:0];
  assign magGt = X.raw[30:0] > Y.raw[30:0];

  always_comb begin
    if (X.f.sign != Y.f.sign) ltTot = X.f.sign;  // Negative side is smaller
    else if (X.f.sign)        ltTot = magGt;     // Both negative, order flips
    else                      ltTot = magLt;
  end

  assign lt = ltTot & ~bothZero;
  assign eq = (X.raw == Y.raw) | bothZero;

  ///////////////////////////////
  // Result select
  ///////////////////////////////
  always_comb begin
    if (xNaN && yNaN)     CmpFp = CanonicalNaN;
    else if (xNaN)        CmpFp = Y.raw;  // Drop the NaN side
    else if (yNaN)        CmpFp = X.raw;
    else if (Funct3 == 3'b001) CmpFp = ltTot ? Y.raw : X.raw;  // fmax
    else                  CmpFp = ltTot ? X.raw : Y.raw;       // fmin
  end

  always_comb begin
    case (Funct3)
      3'b010:  CmpInt = eq & ~anyNaN;         // feq
      3'b001:  CmpInt = lt & ~anyNaN;         // flt
      3'b000:  CmpInt = (lt | eq) & ~anyNaN;  // fle
      default: CmpInt = 1'b0;
    endcase
  end

  // feq and min/max are quiet, flt/fle signal on any NaN
  assign Invalid = (IsMinMax || Funct3 == 3'b010) ? anySNaN : anyNaN;

endmodule

// File: fpuExecute.sv
//////////////////////////////
// Execute stage: sign injection, compare, fclass, moves
//////////////////////////////
`timescale 1ns/1ns

module fpuExecute #(
  parameter int Xlen = 64  // Integer result width
) (
  input  fpuPipePkg::fpCtrl_t Ctrl,
  input  logic [31:0]         X, Y,
  input  logic [Xlen-1:0]     IntSrc,
  output logic [31:0]         FpRes,
  output logic [Xlen-1:0]     IntRes,
  output logic [4:0]          Flags
);
  import fpuIsaPkg::*;
  import fpuPipePkg::*;

  fpWord_u     xw, yw;
  fpClass_t    xCls, yCls;
  logic [31:0] cmpFp;
  logic        cmpInt, cmpInvalid;
  logic        sgnBit;  // Injected sign
  logic        isMinMax;

  assign xw.raw   = X;
  assign yw.raw   = Y;
  assign isMinMax = (Ctrl.resSel == MinMax);

  fpuUnpack unpackX (.X(xw), .Cls(xCls));
  fpuUnpack unpackY (.X(yw), .Cls(yCls));

  fpuCompare compare (
    .X(xw), .Y(yw), .XCls(xCls), .YCls(yCls),
    .Funct3(Ctrl.funct3), .IsMinMax(isMinMax),
    .CmpFp(cmpFp), .CmpInt(cmpInt), .Invalid(cmpInvalid)
  );

  always_comb begin
    case (Ctrl.funct3[1:0])
      2'b00:   sgnBit = yw.f.sign;              // fsgnj
      2'b01:   sgnBit = ~yw.f.sign;             // fsgnjn
      default: sgnBit = xw.f.sign ^ yw.f.sign;  // fsgnjx
    endcase
  end

  ///////////////////////////////
  // Result muxes
  ///////////////////////////////
  always_comb begin
    case (Ctrl.resSel)
      Sgnj:    FpRes = {sgnBit, xw.raw[30:0]};
      MinMax:  FpRes = cmpFp;
      MvWX:    FpRes = IntSrc[31:0];  // Low word, bits pass untouched
      default: FpRes = '0;
    endcase
  end

  always_comb begin
    case (Ctrl.resSel)
      Cmp:     IntRes = {{(Xlen-1){1'b0}}, cmpInt};
      Class:   IntRes = {{(Xlen-10){1'b0}}, xCls};
      MvXW:    IntRes = {{(Xlen-32){X[31]}}, X};  // Sign extend to Xlen
      default: IntRes = '0;
    endcase
  end

  // NV only, NX/UF/OF/DZ never set here
  assign Flags = {cmpInvalid & (isMinMax | (Ctrl.resSel == Cmp)), 4'b0000};

endmodule

// File: fpu.sv
//////////////////////////////
// Single-precision FPU top: four-stage pipe D/E/M/W
// with regfile, forwarding and writeback outputs
//////////////////////////////
`timescale 1ns/1ns

module fpu #(
  parameter int Xlen = 64  // Integer register width
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               Stall,
  input  logic               InstrValid,
  input  fpuIsaPkg::instrR_t Instr,
  input  logic [Xlen-1:0]    IntSrc,        // rs1 value for fmv.w.x
  output logic               IllegalInstr,
  output logic               FRegWriteW,
  output logic [4:0]         RdW,
  output logic [31:0]        FResultW,
  output logic               IntWriteW,
  output logic [Xlen-1:0]    IntResW,
  output logic [4:0]         FlagsW
);
  import fpuPipePkg::*;

  fpCtrl_t         ctrlD, ctrlE, ctrlM, ctrlW;
  logic [31:0]     rd1D, rd2D, rd1E, rd2E;  // Regfile reads
  logic [4:0]      adr1E, adr2E;
  logic [Xlen-1:0] intSrcE;
  fwdSel_t         fwdX, fwdY;
  logic [31:0]     xE, yE;                  // Operands after forwarding
  logic [31:0]     fpResE, fpResM, fpResW;
  logic [Xlen-1:0] intResE, intResM, intResW;
  logic [4:0]      flagsE, flagsM, flagsW;

  function automatic logic [31:0] fwdMux(fwdSel_t sel, logic [31:0] rf, logic [31:0] w,
                                         logic [31:0] m);
    case (sel)
      FwdM:    return m;
      FwdW:    return w;
      default: return rf;
    endcase
  endfunction

  ///////////////////////////////
  // Decode
  ///////////////////////////////
  fpuDecoder decoder (.Instr, .InstrValid(InstrValid & ~Stall), .Ctrl(ctrlD), .IllegalInstr);

  fpuRegFile regFile (
    .clk, .rst, .We(FRegWriteW), .Ra1(Instr.rs1), .Ra2(Instr.rs2), .Wa(ctrlW.rd),
    .Wd(fpResW), .Rd1(rd1D), .Rd2(rd2D)
  );

  always_ff @(posedge clk) begin
    if (rst)         ctrlE <= '0;
    else if (!Stall) ctrlE <= ctrlD;  // Hold while stalled
  end

  always_ff @(posedge clk) begin
    if (Stall) begin  // Refresh held operands, W result leaves next cycle
      rd1E <= xE;
      rd2E <= yE;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      adr1E   <= Instr.rs1;
      adr2E   <= Instr.rs2;
      intSrcE <= IntSrc;
    end
  end

  ///////////////////////////////
  // Execute
  ///////////////////////////////
  fpuForward forward (.Adr1E(adr1E), .Adr2E(adr2E), .CtrlE(ctrlE), .CtrlM(ctrlM),
                      .CtrlW(ctrlW), .FwdX(fwdX), .FwdY(fwdY));

  assign xE = fwdMux(fwdX, rd1E, fpResW, fpResM);
  assign yE = fwdMux(fwdY, rd2E, fpResW, fpResM);

  fpuExecute #(.Xlen(Xlen)) execute (
    .Ctrl(ctrlE), .X(xE), .Y(yE), .IntSrc(intSrcE),
    .FpRes(fpResE), .IntRes(intResE), .Flags(flagsE)
  );

  // E/M, held on stall
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM  <= '0;
      flagsM <= '0;
    end else if (!Stall) begin
      ctrlM  <= ctrlE;
      flagsM <= flagsE & {5{ctrlE.valid}};  // Bubbles raise nothing
    end
  end

  always_ff @(posedge clk) begin
    if (!Stall) begin
      fpResM  <= fpResE;
      intResM <= intResE;
    end
  end

  // M/W takes a bubble on stall so M writes back once
  always_ff @(posedge clk) begin
    if (rst || Stall) begin
      ctrlW  <= '0;
      flagsW <= '0;
    end else begin
      ctrlW  <= ctrlM;
      flagsW <= flagsM;
    end
  end

  always_ff @(posedge clk) begin
    fpResW  <= fpResM;
    intResW <= intResM;
  end

  ///////////////////////////////
  // Writeback
  ///////////////////////////////
  assign FRegWriteW = ctrlW.valid & ctrlW.fRegWrite;
  assign IntWriteW  = ctrlW.valid & ctrlW.intWrite;
  assign RdW        = ctrlW.rd;
  assign FResultW   = fpResW;
  assign IntResW    = intResW;
  assign FlagsW     = flagsW;

endmodule

// File: tbFpu.sv
//////////////////////////////
// FPU testbench: directed tests against a shadow-register model
//////////////////////////////
`timescale 1ns/1ns

module tbFpu;
  import fpuIsaPkg::*;

  localparam int ResetCycles = 16;
  localparam int NumInstr    = 27 + 18 + 510 + 20 + 9;  // Per test, in run order
  localparam int IdleCycles  = 6 * 8 + 2 * 5;           // Drains and stall windows
  localparam int CycleLimit  = 2 * (ResetCycles + NumInstr + IdleCycles);

  // Expected writeback of one instruction
  typedef struct packed {
    logic        isFp;    // FP register write, else integer result
    logic [4:0]  rd;
    logic [31:0] fpVal;
    logic [63:0] intVal;
    logic [4:0]  flags;
  } wbExp_t;

  logic        clk, rst, stall, instrValid;
  instrR_t     instr;
  logic [63:0] intSrc, intResW;
  logic        illegalInstr, fRegWriteW, intWriteW;
  logic [4:0]  rdW, flagsW;
  logic [31:0] fResultW;

  logic [31:0] fRegs [32];  // Shadow FP registers, program order
  wbExp_t      expQ [$];    // Pending writebacks, oldest first
  wbExp_t      head;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  integer      seed;

  fpu #(.Xlen(64)) UUT (
    .clk, .rst, .Stall(stall), .InstrValid(instrValid), .Instr(instr), .IntSrc(intSrc),
    .IllegalInstr(illegalInstr), .FRegWriteW(fRegWriteW), .RdW(rdW), .FResultW(fResultW),
    .IntWriteW(intWriteW), .IntResW(intResW), .FlagsW(flagsW)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ///////////////////////////////
  // Reference model
  ///////////////////////////////
  // fclass bit index, 0 = -inf up to 9 = quiet NaN
  function automatic int classIdx(logic [31:0] w);
    logic       s;
    logic [7:0] e;
    logic [22:0] m;
    s = w[31];
    e = w[30:23];
    m = w[22:0];
    if (e == 8'hFF && m != '0) return m[22] ? 9 : 8;
    if (e == 8'hFF) return s ? 0 : 7;
    if (e != 8'h00) return s ? 1 : 6;
    if (m != '0) return s ? 2 : 5;
    return s ? 3 : 4;
  endfunction

  // Signed magnitude as one integer, both zeros map to 0
  function automatic longint orderKey(logic [31:0] w);
    longint mag;
    mag = longint'({33'd0, w[30:0]});
    return w[31] ? -mag : mag;
  endfunction

  function automatic logic [63:0] randWord();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [4:0] randReg();
    logic [31:0] r;
    r = {$random(seed)} % 16 + 1;  // f1..f16
    return r[4:0];
  endfunction

  function automatic instrR_t encode(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, FpOpcode};
  endfunction

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  // Drive one word for a cycle, predict its writeback
  task automatic issue(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3,
                       logic [4:0] rd, logic [63:0] src);
    wbExp_t      e;
    logic [31:0] x, y;
    logic        legal, nanX, nanY, sig;
    longint      kx, ky;
    x     = fRegs[rs1];
    y     = fRegs[rs2];
    nanX  = classIdx(x) >= 8;
    nanY  = classIdx(y) >= 8;
    sig   = classIdx(x) == 8 || classIdx(y) == 8;  // Any signaling NaN
    kx    = orderKey(x);
    ky    = orderKey(y);
    e     = '0;
    e.rd  = rd;
    legal = 1'b1;
    case (f7)
      Funct7Sgnj: begin
        e.isFp = 1'b1;
        legal  = f3 <= 3'd2;
        case (f3)
          3'd0:    e.fpVal = {y[31], x[30:0]};
          3'd1:    e.fpVal = {~y[31], x[30:0]};
          default: e.fpVal = {x[31] ^ y[31], x[30:0]};
        endcase
      end
      Funct7MinMax: begin
        e.isFp     = 1'b1;
        legal      = f3 <= 3'd1;
        e.flags[4] = sig;
        if (nanX && nanY) e.fpVal = CanonicalNaN;
        else if (nanX) e.fpVal = y;  // Number beats NaN
        else if (nanY) e.fpVal = x;
        else if (kx == ky) e.fpVal = (x[31] ^ f3[0]) ? x : y;  // -0 below +0
        else e.fpVal = ((kx < ky) ^ f3[0]) ? x : y;
      end
      Funct7Cmp: begin
        legal      = f3 <= 3'd2;
        e.flags[4] = (f3 == 3'd2) ? sig : (nanX || nanY);
        if (!nanX && !nanY)
          e.intVal[0] = (f3 == 3'd2) ? kx == ky : (f3 == 3'd1) ? kx < ky : kx <= ky;
      end
      Funct7MvXClass: begin
        legal    = rs2 == 5'd0 && f3 <= 3'd1;
        e.intVal = f3[0] ? 64'd1 << classIdx(x) : {{32{x[31]}}, x};
      end
      Funct7MvWX: begin
        e.isFp  = 1'b1;
        legal   = rs2 == 5'd0 && f3 == 3'd0;
        e.fpVal = src[31:0];
      end
      default: legal = 1'b0;
    endcase
    @(posedge clk);
    instr      <= encode(f7, rs2, rs1, f3, rd);
    instrValid <= 1'b1;
    intSrc     <= src;
    if (legal) begin
      expQ.push_back(e);
      if (e.isFp) fRegs[rd] = e.fpVal;
    end
    @(negedge clk);
    checkValue("IllegalInstr", 64'(illegalInstr), 64'(!legal));
  endtask

  task automatic drain();
    @(posedge clk);
    instrValid <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // Room for a late or doubled writeback
  endtask

  // Stall for n cycles while a live word sits on the input
  task automatic stallFor(int n);
    @(posedge clk);
    stall      <= 1'b1;
    instrValid <= 1'b1;
    instr      <= encode(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'd30);
    intSrc     <= randWord();
    repeat (n) @(posedge clk);
    stall      <= 1'b0;
    instrValid <= 1'b0;
  endtask

  ///////////////////////////////
  // Tests
  ///////////////////////////////
  task automatic resetState();
    @(negedge clk);
    checkValue("FRegWriteW", 64'(fRegWriteW), 64'd0);
    checkValue("IntWriteW", 64'(intWriteW), 64'd0);
    checkValue("IllegalInstr", 64'(illegalInstr), 64'd0);
    checkValue("FlagsW", 64'(flagsW), 64'd0);
  endtask

  task automatic moveRoundTrip();
    for (int i = 0; i < 9; i++) begin
      issue(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'(i + 1), randWord());
      repeat (i % 3) issue(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'd31, randWord());  // M, W, bypass
      issue(Funct7MvXClass, 5'd0, 5'(i + 1), 3'd0, 5'(i + 10), 64'd0);
    end
    drain();
  endtask

  task automatic signInjection();
    for (int i = 0; i < 18; i++)
      issue(Funct7Sgnj, randReg(), randReg(), 3'(i % 3), 5'(11 + i % 6), 64'd0);
    drain();
  endtask

  task automatic compareCases();
    logic [31:0] vals [10];
    logic [63:0] rw;
    vals = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000, CanonicalNaN,
             32'h7F80_0001, 32'h3F80_0000, 32'hC020_0000, 32'h0, 32'h0};
    rw      = randWord();
    vals[8] = rw[31:0];
    vals[9] = rw[63:32];
    for (int i = 0; i < 10; i++)
      issue(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'(16 + i), {32'd0, vals[i]});
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 10; j++) begin
        issue(Funct7MinMax, 5'(16 + j), 5'(16 + i), 3'd0, 5'd26, 64'd0);  // fmin
        issue(Funct7MinMax, 5'(16 + j), 5'(16 + i), 3'd1, 5'd26, 64'd0);  // fmax
        issue(Funct7Cmp, 5'(16 + j), 5'(16 + i), 3'd2, 5'd5, 64'd0);      // feq
        issue(Funct7Cmp, 5'(16 + j), 5'(16 + i), 3'd1, 5'd5, 64'd0);      // flt
        issue(Funct7Cmp, 5'(16 + j), 5'(16 + i), 3'd0, 5'd5, 64'd0);      // fle
      end
    end
    drain();
  endtask

  task automatic classifyAll();
    logic [31:0] vals [10];
    // One per class, in fclass bit order
    vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
             32'h0040_0000, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
    for (int i = 0; i < 10; i++)
      issue(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'(1 + i), {32'd0, vals[i]});
    for (int i = 0; i < 10; i++)
      issue(Funct7MvXClass, 5'd0, 5'(1 + i), 3'd1, 5'(1 + i), 64'd0);
    drain();
  endtask

  task automatic illegalAndStall();
    issue(Funct7Sgnj | 7'b000_0001, 5'd2, 5'd1, 3'd0, 5'd20, 64'd0);  // fmt 01
    issue(7'b000_1100, 5'd2, 5'd1, 3'd0, 5'd20, 64'd0);               // fdiv, dropped
    issue(Funct7MvXClass, 5'd3, 5'd1, 3'd1, 5'd20, 64'd0);            // rs2 must be 0
    drain();
    // Dependent chain with two stall windows
    issue(Funct7MvWX, 5'd0, 5'd0, 3'd0, 5'd1, randWord());
    issue(Funct7Sgnj, 5'd1, 5'd1, 3'd1, 5'd2, 64'd0);
    stallFor(4);
    issue(Funct7Sgnj, 5'd1, 5'd2, 3'd2, 5'd3, 64'd0);
    issue(Funct7MinMax, 5'd2, 5'd3, 3'd1, 5'd4, 64'd0);
    stallFor(3);
    issue(Funct7MvXClass, 5'd0, 5'd4, 3'd0, 5'd6, 64'd0);
    issue(Funct7Cmp, 5'd4, 5'd3, 3'd1, 5'd7, 64'd0);
    drain();
  endtask

  // Writeback monitor, oldest expectation first
  always @(negedge clk) begin
    if (!rst && (fRegWriteW || intWriteW)) begin
      assert (expQ.size() != 0) else begin
        errors++;
        $display("Unexpected writeback at %0t to register %0d", $time, rdW);
      end
      if (expQ.size() != 0) begin
        head = expQ.pop_front();
        checkValue("FRegWriteW", 64'(fRegWriteW), 64'(head.isFp));
        checkValue("IntWriteW", 64'(intWriteW), 64'(!head.isFp));
        checkValue("RdW", 64'(rdW), 64'(head.rd));
        if (head.isFp) checkValue("FResultW", 64'(fResultW), 64'(head.fpVal));
        else checkValue("IntResW", intResW, head.intVal);
        checkValue("FlagsW", 64'(flagsW), 64'(head.flags));
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CycleLimit) begin
      $display("Timeout after %0d cycles with %0d writebacks pending", cycles, expQ.size());
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    seed       = 32'h80af_39f7;
    rst        = 1'b1;
    stall      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    intSrc     = '0;
    for (int i = 0; i < 32; i++) fRegs[i] = '0;  // Regfile clears on reset
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    resetState();
    moveRoundTrip();
    signInjection();
    compareCases();
    classifyAll();
    illegalAndStall();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

endmodule

// File: filelist.f
fpuIsaPkg.sv
fpuPipePkg.sv
fpuDecoder.sv
fpuRegFile.sv
fpuForward.sv
fpuUnpack.sv
fpuCompare.sv
fpuExecute.sv
fpu.sv
tbFpu.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tbFpu
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
